// ==== testbench/sdCmdCases.txt ====
# columns in hex: divHalf bypass index argument
# bypass 1 checks o_sdClk against i_CLK before the frame is sent divided
3 0 00 00000000
0 1 08 000001AA
1 0 37 00000000
2 1 29 40FF8000
7 0 02 00000000
4 0 03 00000000
5 1 09 AAAA0000
6 0 07 12340000
1 0 10 00000200
0 0 11 00001234
2 0 3F FFFFFFFF
7 1 2A 5A5A5A5A

// ==== sim.f ====
logic/sdClkPkg.sv
logic/sdCmdPkg.sv
logic/sdClkDivider.sv
logic/sdCrc7.sv
logic/sdCmdSender.sv
logic/sdCmdTop.sv
testbench/sdCmdTb.sv

// ==== runSim.sh ====
#!/bin/sh
# build the SD command path testbench with Verilator and run it
set -e
cd "$(dirname "$0")"

verilator --binary --timing -f sim.f --top-module sdCmdTb -o sdCmdSim

./obj_dir/sdCmdSim > sim.log 2>&1 || true
cat sim.log

if grep -q "CHECKS FAILED" sim.log; then
  echo "simulation failed"
  exit 1
fi

if ! grep -q "ALL CHECKS PASSED" sim.log; then
  echo "simulation ended without a result"
  exit 1
fi

echo "simulation passed"

// ==== testbench/sdCmdTb.sv ====
/* testbench for the SD command path, reads cases, checks divider, bypass and frames
   with a reference CRC7 and LFSR driven extra commands */

module sdCmdTb;
  timeunit 1ns;
  timeprecision 100ps;

  localparam int EXTRA_CMDS = 3;

  logic i_CLK = 1'b0;
  logic i_reset = 1'b1;
  sdClkPkg::divCountT i_divHalf = sdClkPkg::divCountT'(3);
  logic i_divEnable = 1'b1;
  logic i_start = 1'b0;
  sdCmdPkg::cmdFrameT i_cmd = '0;
  logic o_sdClk, o_cmdLine, o_busy, o_done;

  int errors = 0;
  int doneCount = 0;
  bit rxBits[$];                   // command bits seen on rising SD clock edges
  logic prevSd = 1'b0;
  logic prevBusy = 1'b0;
  logic armed = 1'b0;              // a frame bit has gone out on a falling edge
  logic [15:0] lfsrState = 16'd64933;
  bit casesReady = 1'b0;
  longint limitNs;

  sdCmdTop u_dut (.*);

  always #10 i_CLK = ~i_CLK;

  task automatic checkValue(input string name, input logic [63:0] got, input logic [63:0] exp);
    if (got !== exp) begin
      errors++;
      $display("error at %0t ns: %s is %0h, expected %0h", $time, name, got, exp);
    end
  endtask

  // x^16 + x^14 + x^13 + x^11 + 1, one step per bit taken
  function automatic logic [31:0] randBits(input int n);
    logic [31:0] r;
    logic fb;
    r = '0;
    for (int k = 0; k < n; k++) begin
      fb = lfsrState[15] ^ lfsrState[13] ^ lfsrState[12] ^ lfsrState[10];
      lfsrState = {lfsrState[14:0], fb};
      r = {r[30:0], fb};
    end
    return r;
  endfunction

  // whole 48 bit frame from the SD rules, crc7 over the 40 head bits
  function automatic logic [47:0] frameOf(input logic [5:0] idx, input logic [31:0] arg);
    logic [39:0] head;
    logic [6:0] crc;
    logic fb;
    head = {1'b0, 1'b1, idx, arg};
    crc = '0;
    for (int k = 39; k >= 0; k--) begin
      fb = head[k] ^ crc[6];
      crc = {crc[5:0], 1'b0} ^ (fb ? 7'h09 : 7'h00);
    end
    return {head, crc, 1'b1};
  endfunction

  // monitor samples at the rising i_CLK edge where DUT outputs are settled
  always @(posedge i_CLK) begin
    if (!i_reset) begin
      if (o_done) doneCount++;
      if (prevSd && !o_sdClk && prevBusy) armed = 1'b1;  // falling edge moved a frame bit
      else if (!prevSd && o_sdClk && armed && o_busy) rxBits.push_back(o_cmdLine);
      if (!o_busy) armed = 1'b0;
    end
    prevSd = o_sdClk;
    prevBusy = o_busy;
  end

  task automatic checkBypass();
    @(negedge i_CLK) i_divEnable = 1'b0;
    repeat (8) begin
      @(posedge i_CLK) #5 checkValue("o_sdClk", 64'(o_sdClk), 64'(i_CLK));
      @(negedge i_CLK) #5 checkValue("o_sdClk", 64'(o_sdClk), 64'(i_CLK));
    end
    @(negedge i_CLK) i_divEnable = 1'b1;
  endtask

  task automatic measurePeriod(input int half);
    logic last;
    int cnt;
    last = o_sdClk;
    do @(negedge i_CLK); while (o_sdClk == last);  // this half may still use the old setting
    repeat (4) begin
      last = o_sdClk;
      cnt = 0;
      do begin
        @(negedge i_CLK);
        cnt++;
      end while (o_sdClk == last);
      checkValue("o_sdClk half period", 64'(cnt), 64'(half + 1));
    end
  endtask

  task automatic sendCommand(input logic [5:0] idx, input logic [31:0] arg);
    int doneBefore;
    logic [47:0] exp;
    exp = frameOf(idx, arg);
    rxBits.delete();
    doneBefore = doneCount;
    @(negedge i_CLK) begin
      i_cmd = {idx, arg};
      i_start = 1'b1;
    end
    @(negedge i_CLK) i_start = 1'b0;
    checkValue("o_busy", 64'(o_busy), 64'(1));
    repeat (3) @(negedge i_CLK);
    i_cmd = ~{idx, arg};  // a start while busy must be dropped
    i_start = 1'b1;
    @(negedge i_CLK) i_start = 1'b0;
    while (doneCount == doneBefore) @(negedge i_CLK);
    checkValue("o_busy", 64'(o_busy), 64'(0));
    checkValue("frame length", 64'(rxBits.size()), 64'(48));
    for (int k = 0; k < 48 && k < rxBits.size(); k++)
      checkValue($sformatf("o_cmdLine bit %0d", k), 64'(rxBits[k]), 64'(exp[47-k]));
    repeat (3 * 2 * (int'(i_divHalf) + 1)) @(negedge i_CLK);
    checkValue("o_done count", 64'(doneCount - doneBefore), 64'(1));
    checkValue("o_busy", 64'(o_busy), 64'(0));
  endtask

  //////////////////////////////
  // watchdog
  //////////////////////////////

  initial begin
    wait (casesReady);
    #(limitNs);
    $display("timeout: the DUT did not finish the commands in time");
    $display("CHECKS FAILED");
    $finish;
  end

  //////////////////////////////
  // main sequence
  //////////////////////////////

  initial begin
    int fd, n, maxDiv;
    string line;
    logic [31:0] cDiv[$], cByp[$], cIdx[$], cArg[$];
    logic [31:0] d, b, x, a;
    logic [5:0] rndIdx;   // index bits come off the LFSR first
    logic [31:0] rndArg;  // then the argument bits
    fd = $fopen("testbench/sdCmdCases.txt", "r");
    if (fd == 0) begin
      errors++;
      $display("could not open the case file testbench/sdCmdCases.txt");
    end else begin
      while (!$feof(fd)) begin
        line = "";
        n = $fgets(line, fd);
        if (n > 0 && line.len() > 1 && line[0] != "#") begin
          if ($sscanf(line, "%h %h %h %h", d, b, x, a) == 4) begin
            cDiv.push_back(d);
            cByp.push_back(b);
            cIdx.push_back(x);
            cArg.push_back(a);
          end
        end
      end
      $fclose(fd);
    end
    maxDiv = 7;  // extra commands draw 3 bit settings
    foreach (cDiv[k]) if (int'(cDiv[k]) > maxDiv) maxDiv = int'(cDiv[k]);
    limitNs = longint'(cDiv.size() + EXTRA_CMDS) * 60 * 2 * (maxDiv + 1) * 20 + 10000;
    casesReady = 1'b1;

    repeat (10) begin
      @(negedge i_CLK);
      checkValue("o_cmdLine", 64'(o_cmdLine), 64'(1));
      checkValue("o_busy", 64'(o_busy), 64'(0));
      checkValue("o_done", 64'(o_done), 64'(0));
    end
    i_reset = 1'b0;
    repeat (4) @(negedge i_CLK);
    checkValue("o_cmdLine", 64'(o_cmdLine), 64'(1));
    checkValue("o_busy", 64'(o_busy), 64'(0));
    checkValue("o_done", 64'(o_done), 64'(0));

    foreach (cDiv[k]) begin
      i_divHalf = sdClkPkg::divCountT'(cDiv[k]);
      measurePeriod(int'(cDiv[k]));
      if (cByp[k] != 0) checkBypass();
      sendCommand(cIdx[k][5:0], cArg[k]);
    end
    repeat (EXTRA_CMDS) begin
      @(negedge i_CLK) i_divHalf = sdClkPkg::divCountT'(randBits(3));
      measurePeriod(int'(i_divHalf));
      rndIdx = 6'(randBits(6));
      rndArg = randBits(32);
      sendCommand(rndIdx, rndArg);
    end

    $display("closing: %0d errors", errors);
    if (errors == 0) begin
      $display("ALL CHECKS PASSED");
    end else begin
      $display("CHECKS FAILED");
    end
    $finish;
  end

endmodule

// ==== logic/sdCmdTop.sv ====
/* SD command path top level, the clock divider driving the command sender */

module sdCmdTop (
  input  logic               i_CLK,
  input  logic               i_reset,
  input  sdClkPkg::divCountT i_divHalf,    // SD clock half period minus one
  input  logic               i_divEnable,  // low passes i_CLK to the card
  input  logic               i_start,      // one cycle command request
  input  sdCmdPkg::cmdFrameT i_cmd,        // index and argument for the request
  output logic               o_sdClk,
  output logic               o_cmdLine,
  output logic               o_busy,
  output logic               o_done
);

  sdClkPkg::clkStrobeT strobes;  // SD clock edges seen from the i_CLK domain

  //////////////////////////////
  // clock generation
  //////////////////////////////

  sdClkDivider u_clkDivider (
    .i_CLK       (i_CLK),
    .i_reset     (i_reset),
    .i_divHalf   (i_divHalf),
    .i_divEnable (i_divEnable),
    .o_sdClk     (o_sdClk),
    .o_strobes   (strobes)
  );

  //////////////////////////////
  // command serialiser
  //////////////////////////////

  sdCmdSender u_cmdSender (
    .i_CLK     (i_CLK),
    .i_reset   (i_reset),
    .i_start   (i_start),
    .i_cmd     (i_cmd),
    .i_strobes (strobes),  // bits move on fall, rise is left for the response path
    .o_cmdLine (o_cmdLine),
    .o_busy    (o_busy),
    .o_done    (o_done)
  );

endmodule

// ==== logic/sdCmdSender.sv ====
/* FSM that serialises one 48 bit SD command frame on falling SD clock edges,
   with the CRC7 accumulator that builds its checksum */

module sdCmdSender (
  input  logic                i_CLK,
  input  logic                i_reset,
  input  logic                i_start,    // one cycle, taken only while idle
  input  sdCmdPkg::cmdFrameT  i_cmd,      // sampled together with i_start
  input  sdClkPkg::clkStrobeT i_strobes,  // only fall is used, the line changes on falling edges
  output logic                o_cmdLine,  // serial command bit, idles high
  output logic                o_busy,     // level for the whole frame
  output logic                o_done      // one cycle when the frame has ended
);

  sdCmdPkg::sendStateT          state;
  sdCmdPkg::bitCountT           bitCount;  // frame bits already driven on the line
  logic [sdCmdPkg::HEAD_BITS-1:0] shiftReg;  // outgoing bits, MSB leaves first
  sdCmdPkg::crc7T               crcValue;
  logic                         accept;      // start taken this cycle
  logic                         shiftNow;    // a frame bit goes out at this fall strobe
  logic                         crcFeed;     // the bit going out is part of the head
  logic                         atHeadEnd;   // the head has gone, the crc comes next
  logic                         atLastBit;   // the end bit goes out at this strobe

  //////////////////////////////
  // strobe decode
  //////////////////////////////

  assign accept    = (state == sdCmdPkg::IDLE) && i_start;  // a start while busy is dropped
  assign shiftNow  = i_strobes.fall
                   && ((state == sdCmdPkg::WAIT_EDGE) || (state == sdCmdPkg::SHIFT));
  assign atHeadEnd = (bitCount == sdCmdPkg::bitCountT'(sdCmdPkg::HEAD_BITS));
  assign atLastBit = (bitCount == sdCmdPkg::bitCountT'(sdCmdPkg::CMD_BITS - 1));
  assign crcFeed   = shiftNow && (bitCount < sdCmdPkg::bitCountT'(sdCmdPkg::HEAD_BITS));

  // checksum runs over the same bits as they leave, so it is ready well before bit 41
  sdCrc7 u_crc7 (
    .i_CLK      (i_CLK),
    .i_reset    (i_reset),
    .i_clear    (accept),
    .i_bitValid (crcFeed),
    .i_bit      (shiftReg[sdCmdPkg::HEAD_BITS-1]),
    .o_crc      (crcValue)
  );

  //////////////////////////////
  // frame shift register
  //////////////////////////////

  always_ff @(posedge i_CLK) begin
    if (accept) begin
      shiftReg <= {1'b0, 1'b1, i_cmd};  // start bit, host transmission bit, index, argument
    end else if (shiftNow) begin
      if (atHeadEnd) begin
        // top crc bit goes straight to the line, the rest waits here with the end bit
        shiftReg <= {crcValue[sdCmdPkg::CRC_BITS-2:0], 1'b1,
                     {(sdCmdPkg::HEAD_BITS - sdCmdPkg::CRC_BITS){1'b0}}};
      end else begin
        shiftReg <= shiftReg << 1;
      end
    end
  end

  //////////////////////////////
  // control FSM
  //////////////////////////////

  always_ff @(posedge i_CLK) begin
    if (i_reset) begin
      state     <= sdCmdPkg::IDLE;
      bitCount  <= '0;
      o_cmdLine <= 1'b1;  // the card sees an idle line
      o_busy    <= 1'b0;
      o_done    <= 1'b0;
    end else begin
      o_done <= 1'b0;  // pulse only
      case (state)
        sdCmdPkg::IDLE: begin
          if (i_start) begin
            bitCount <= '0;
            o_busy   <= 1'b1;
            state    <= sdCmdPkg::WAIT_EDGE;
          end
        end
        sdCmdPkg::WAIT_EDGE: begin
          // first fall strobe puts the start bit out
          if (i_strobes.fall) begin
            o_cmdLine <= shiftReg[sdCmdPkg::HEAD_BITS-1];
            bitCount  <= bitCount + 1'b1;
            state     <= sdCmdPkg::SHIFT;
          end
        end
        sdCmdPkg::SHIFT: begin
          if (i_strobes.fall) begin
            o_cmdLine <= atHeadEnd ? crcValue[sdCmdPkg::CRC_BITS-1]
                                   : shiftReg[sdCmdPkg::HEAD_BITS-1];
            bitCount  <= bitCount + 1'b1;
            if (atLastBit) begin
              state <= sdCmdPkg::FINISH;  // end bit is now on the line
            end
          end
        end
        sdCmdPkg::FINISH: begin
          // end bit has been held a full SD clock period, line stays high from here
          if (i_strobes.fall) begin
            o_busy <= 1'b0;
            o_done <= 1'b1;
            state  <= sdCmdPkg::IDLE;
          end
        end
        default: state <= sdCmdPkg::IDLE;
      endcase
    end
  end

endmodule

// ==== logic/sdCrc7.sv ====
/* serial CRC7 accumulator over the head of an SD command frame,
   one bit taken per valid strobe */

module sdCrc7 (
  input  logic            i_CLK,
  input  logic            i_reset,
  input  logic            i_clear,     // start of a new frame
  input  logic            i_bitValid,  // i_bit is the next frame bit
  input  logic            i_bit,
  output sdCmdPkg::crc7T  o_crc        // checksum of all bits taken since the clear
);

  sdCmdPkg::crc7T crcReg;
  logic           feedback;

  // the bit leaving the top of the register decides whether the polynomial is folded in
  assign feedback = i_bit ^ crcReg[sdCmdPkg::CRC_BITS-1];

  // shift left and xor in the taps at bits 0 and 3 when the feedback is set
  always_ff @(posedge i_CLK) begin
    if (i_reset || i_clear) begin
      crcReg <= '0;
    end else if (i_bitValid) begin
      crcReg <= {crcReg[sdCmdPkg::CRC_BITS-2:0], 1'b0}
              ^ ({sdCmdPkg::CRC_BITS{feedback}} & sdCmdPkg::CRC_POLY);
    end
  end

  assign o_crc = crcReg;  // ready the cycle after the last valid bit

endmodule

// ==== logic/sdClkDivider.sv ====
/* SD clock divider with reset edge load pulse, reloading down counter, toggle flop,
   edge strobes and bypass multiplexer */

module sdClkDivider (
  input  logic                i_CLK,        // system clock, also the bypass source
  input  logic                i_reset,      // held reset only loads the counter once
  input  sdClkPkg::divCountT  i_divHalf,    // half period minus one, in i_CLK cycles
  input  logic                i_divEnable,  // high selects the divided clock
  output logic                o_sdClk,      // clock driven onto the SD bus
  output sdClkPkg::clkStrobeT o_strobes     // edge markers in the i_CLK domain
);

  logic               resetD;      // reset delayed by one cycle
  logic               resetDD;     // reset delayed by two cycles
  logic               resetPulse;  // one cycle at the leading edge of reset
  logic               countZero;   // terminal count of the down counter
  logic               counterLoad;
  sdClkPkg::divCountT count;
  logic               toggle;      // the divided clock itself

  //////////////////////////////
  // reset edge detect
  //////////////////////////////

  // a held reset must not freeze the divided clock, so only its leading edge is used
  // the sender sits in reset while the SD clock keeps running underneath it
  always_ff @(posedge i_CLK) begin
    resetD  <= i_reset;
    resetDD <= resetD;
  end

  assign resetPulse = resetD & ~resetDD;  // high for exactly one cycle per reset

  //////////////////////////////
  // reloading down counter
  //////////////////////////////

  assign countZero   = (count == '0);
  assign counterLoad = resetPulse | countZero;  // start value on reset or each terminal count

  // counts every cycle with no enable, a new i_divHalf takes effect at the next reload
  always_ff @(posedge i_CLK) begin
    if (counterLoad) begin
      count <= i_divHalf;
    end else begin
      count <= count - sdClkPkg::divCountT'(1);
    end
  end

  //////////////////////////////
  // toggle flop
  //////////////////////////////

  // each terminal count ends one half period of the SD clock
  always_ff @(posedge i_CLK) begin
    if (resetPulse) begin
      toggle <= 1'b0;  // the clock starts from its low phase
    end else if (countZero) begin
      toggle <= ~toggle;
    end
  end

  // the toggle value tells which way it flips at the end of the terminal count cycle
  assign o_strobes.rise = countZero & ~toggle;
  assign o_strobes.fall = countZero & toggle;

  //////////////////////////////
  // bypass
  //////////////////////////////

  // with division off the card runs straight from i_CLK
  // strobes still come from the counter so the command timing is unchanged
  assign o_sdClk = i_divEnable ? toggle : i_CLK;

endmodule

// ==== logic/sdCmdPkg.sv ====
/* command frame types, field widths, CRC7 polynomial and sender states
   for the SD command path */

package sdCmdPkg;

  //////////////////////////////
  // frame layout
  //////////////////////////////

  localparam int CMD_BITS = 48;  // start, transmission, index, argument, crc, end
  localparam int CRC_BITS = 7;

  // bits covered by the checksum, everything ahead of the crc field
  localparam int HEAD_BITS = CMD_BITS - CRC_BITS - 1;

  // x^7 + x^3 + 1, the x^7 term is implied by the shift out of the top bit
  localparam logic [CRC_BITS-1:0] CRC_POLY = 7'b000_1001;

  typedef logic [5:0]          cmdIndexT;  // command number, CMD0 to CMD63
  typedef logic [31:0]         cmdArgT;    // argument word, sent MSB first
  typedef logic [CRC_BITS-1:0] crc7T;
  typedef logic [5:0]          bitCountT;  // counts frame bits already on the line

  // index sits above arg so the struct lines up with the wire order of the frame
  typedef struct packed {
    cmdIndexT index;
    cmdArgT   arg;
  } cmdFrameT;

  //////////////////////////////
  // sender FSM
  //////////////////////////////

  typedef enum logic [1:0] {IDLE, WAIT_EDGE, SHIFT, FINISH} sendStateT;

endpackage

// ==== logic/sdClkPkg.sv ====
/* clock generation types and constants for the SD host
   divider count width, half period count type and edge strobe struct */

package sdClkPkg;

  //////////////////////////////
  // divider sizing
  //////////////////////////////

  // wide enough to slow a fast system clock down to the 400 kHz card identification rate
  localparam int COUNT_WIDTH = 10;

  // half period of the SD clock minus one, counted in i_CLK cycles
  typedef logic [COUNT_WIDTH-1:0] divCountT;

  //////////////////////////////
  // edge strobes
  //////////////////////////////

  // each field is high for the one i_CLK cycle at whose end the divided clock changes
  // rise is kept for the response path that samples on rising edges
  typedef struct packed {
    logic rise;  // divided clock goes high after this cycle
    logic fall;  // divided clock goes low after this cycle
  } clkStrobeT;

endpackage
